// ==== build.f ====
+incdir+verilog
verilog/isaPkg.sv
verilog/datapathPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/singleCycleCpu.sv
tb/cpuChecker.sv
tb/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the single-cycle CPU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module cpuTb \
    -Mdir obj_dir -o cpuSim \
    && ./obj_dir/cpuSim > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null

grep -q "No errors" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0

// ==== tb/cpuChecker.sv ====
// Retire trace checker
// compares each retired instruction with the expected record and counts mismatches
`default_nettype none

module cpuChecker
    import isaPkg::*, datapathPkg::*;
(
    input  wire logic    clk,
    input  wire logic    run,
    input  wire logic    retireValid,
    input  wire retire_t retire,
    output logic         done,
    output logic         timedOut,
    output int           errorCount,
    output int           checkCount
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int EXP_COUNT   = 21;
    localparam int CYCLE_LIMIT = EXP_COUNT + 20;

    retire_t expTable [EXP_COUNT];
    int      entryCount;
    int      runCycles;

    task automatic addRecord(input word_t pc, input logic wbEn, input regIdx_t wbReg,
                             input word_t wbData, input logic memWe, input word_t memAddr,
                             input word_t memData);
        retire_t rec;
        rec.pc      = pc;
        rec.wbEn    = wbEn;
        rec.wbReg   = wbReg;
        rec.wbData  = wbData;
        rec.memWe   = memWe;
        rec.memAddr = memAddr;
        rec.memData = memData;
        expTable[entryCount] = rec;
        entryCount++;
    endtask

    task automatic expectRegWrite(input word_t pc, input regIdx_t wbReg, input word_t wbData);
        addRecord(pc, 1'b1, wbReg, wbData, 1'b0, '0, '0);
    endtask

    task automatic expectStore(input word_t pc, input word_t memAddr, input word_t memData);
        addRecord(pc, 1'b0, '0, '0, 1'b1, memAddr, memData);
    endtask

    task automatic expectNoWrite(input word_t pc);
        addRecord(pc, 1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic compareField(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            errorCount++;
            $display("ERR %0t: retirement %0d field %s is %h, expected %h",
                     $time, checkCount, name, got, want);
        end
    endtask

    initial begin
        done       = 1'b0;
        timedOut   = 1'b0;
        errorCount = 0;
        checkCount = 0;
        runCycles  = 0;
        entryCount = 0;
        expectRegWrite(32'h00, 5'd1, 32'h00000005);
        expectRegWrite(32'h04, 5'd2, 32'hfffffffd);  // -3 sign extended
        expectRegWrite(32'h08, 5'd3, 32'h00000002);
        expectRegWrite(32'h0c, 5'd4, 32'h00000008);  // 5 - (-3)
        expectRegWrite(32'h10, 5'd5, 32'h00000005);
        expectRegWrite(32'h14, 5'd6, 32'hfffffffd);
        expectRegWrite(32'h18, 5'd7, 32'h00000001);  // -3 < 5 signed
        expectRegWrite(32'h1c, 5'd8, 32'h00000000);
        expectRegWrite(32'h20, 5'd0, 32'h0000000a);  // reported, but r0 keeps zero
        expectRegWrite(32'h24, 5'd9, 32'h00000005);  // r0 reads back as zero
        expectStore(32'h28, 32'h0000000c, 32'h00000008);
        expectRegWrite(32'h2c, 5'd10, 32'h00000008); // loaded word, not the address
        expectNoWrite(32'h30);                         // taken, skips 0x34
        expectNoWrite(32'h38);                         // not taken
        expectRegWrite(32'h3c, 5'd31, 32'h00000040);  // jal links pc+4
        expectRegWrite(32'h48, 5'd13, 32'h00000001);
        expectNoWrite(32'h4c);                         // jr back to 0x40
        expectRegWrite(32'h40, 5'd12, 32'h00000007);
        expectNoWrite(32'h44);                         // j to itself
        expectNoWrite(32'h44);
        expectNoWrite(32'h44);
    end

    always @(posedge clk) begin
        if (retireValid && !run) begin
            errorCount++;
            $display("unexpected retirement at time %0t while run is low", $time);
        end
        if (run && !done && !timedOut) begin
            runCycles++;
            if (!retireValid) begin
                errorCount++;
                $display("no instruction retired at time %0t although run is high", $time);
            end else if (checkCount < EXP_COUNT) begin
                compareField("pc", retire.pc, expTable[checkCount].pc);
                compareField("wbEn", word_t'(retire.wbEn), word_t'(expTable[checkCount].wbEn));
                compareField("wbReg", word_t'(retire.wbReg),
                             word_t'(expTable[checkCount].wbReg));
                compareField("wbData", retire.wbData, expTable[checkCount].wbData);
                compareField("memWe", word_t'(retire.memWe),
                             word_t'(expTable[checkCount].memWe));
                compareField("memAddr", retire.memAddr, expTable[checkCount].memAddr);
                compareField("memData", retire.memData, expTable[checkCount].memData);
                checkCount++;
                if (checkCount == EXP_COUNT) begin
                    done = 1'b1;
                end
            end
            if (!done && runCycles >= CYCLE_LIMIT) begin
                timedOut = 1'b1;
                $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                         checkCount, EXP_COUNT, runCycles);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/cpuTb.sv ====
// CPU testbench top
// loads a program through the loader port, runs the core and hands the trace to the checker
`default_nettype none

module cpuTb
    import isaPkg::*, datapathPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN = 20;

    // word index i sits at byte address 4*i
    localparam word_t PROG [PROG_LEN] = '{
        32'h20010005, // 0x00 addi r1, r0, 5
        32'h2002fffd, // 0x04 addi r2, r0, -3
        32'h00221820, // 0x08 add  r3, r1, r2
        32'h00222022, // 0x0c sub  r4, r1, r2
        32'h00222824, // 0x10 and  r5, r1, r2
        32'h00223025, // 0x14 or   r6, r1, r2
        32'h0041382a, // 0x18 slt  r7, r2, r1
        32'h0022402a, // 0x1c slt  r8, r1, r2
        32'h00210020, // 0x20 add  r0, r1, r1
        32'h00014820, // 0x24 add  r9, r0, r1
        32'hac04000c, // 0x28 sw   r4, 12(r0)
        32'h8c0a000c, // 0x2c lw   r10, 12(r0)
        32'h10290001, // 0x30 beq  r1, r9, +1
        32'h200b0063, // 0x34 addi r11, r0, 99
        32'h10220001, // 0x38 beq  r1, r2, +1
        32'h0c000012, // 0x3c jal  0x48
        32'h200c0007, // 0x40 addi r12, r0, 7
        32'h08000011, // 0x44 j    0x44
        32'h200d0001, // 0x48 addi r13, r0, 1
        32'h03e00008  // 0x4c jr   r31
    };

    logic    clk;
    logic    rstN;
    logic    run;
    logic    imemWe;
    word_t   imemAddr;
    word_t   imemData;
    logic    retireValid;
    retire_t retire;
    logic    done;
    logic    timedOut;
    int      errorCount;
    int      checkCount;

    initial clk = 1'b0;

    always #4 clk = ~clk; // 8 ns period

    singleCycleCpu dut (
        .clk         (clk),
        .rstN        (rstN),
        .run         (run),
        .imemWe      (imemWe),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .retireValid (retireValid),
        .retire      (retire)
    );

    cpuChecker chk (
        .clk         (clk),
        .run         (run),
        .retireValid (retireValid),
        .retire      (retire),
        .done        (done),
        .timedOut    (timedOut),
        .errorCount  (errorCount),
        .checkCount  (checkCount)
    );

    // inputs change 1 ns after the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        rstN     = 1'b0;
        run      = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        repeat (3) stepCycle();
        rstN = 1'b1;

        // program goes in with the core stopped
        for (int i = 0; i < PROG_LEN; i++) begin
            imemWe   = 1'b1;
            imemAddr = word_t'(i);
            imemData = PROG[i];
            stepCycle();
        end
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        repeat (2) stepCycle(); // idle, nothing may retire here

        run = 1'b1;
        while (!done && !timedOut) begin
            stepCycle();
        end
        run = 1'b0;

        $display("checked %0d retirements, %0d errors", checkCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_config.svh ====
// CPU configuration
// machine word width and the sizes of the memories and register file
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// machine word, data and address
`define DATA_W 32

// instruction memory depth in words
`define IMEM_WORDS 64

// data memory depth in words
`define DMEM_WORDS 64

// general purpose registers, r0 reads as zero
`define REG_COUNT 32

`endif

// ==== verilog/datapathPkg.sv ====
// Datapath package
// control bundle and the records passed between the stages
`default_nettype none

package datapathPkg;

    import isaPkg::*;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOp_e;

    typedef struct packed {
        logic   regWrite;
        logic   aluSrcImm; // b operand is the immediate
        logic   memWrite;
        logic   memToReg;
        logic   branch;
        logic   jump;
        logic   jumpReg;   // jump through rs
        logic   link;      // write pc+4 into r31
        logic   regDst;    // rd when set, else rt
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        word_t       readData1;
        word_t       readData2;
        word_t       seImm;
        jumpTarget_t target;
        regIdx_t     writeReg;
        word_t       pcPlus4;
    } decodeOut_t;

    typedef struct packed {
        ctrl_t   ctrl;
        word_t   aluResult;
        word_t   storeData;
        regIdx_t writeReg;
        word_t   pcPlus4;
        logic    takeBranch;
        word_t   branchTarget;
        logic    takeJump;
        word_t   jumpTarget;
    } execOut_t;

    typedef struct packed {
        word_t   pc;
        logic    wbEn;
        regIdx_t wbReg;
        word_t   wbData;
        logic    memWe;
        word_t   memAddr;
        word_t   memData;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/decodeStage.sv ====
// Decode stage
// splits the instruction, builds the control bundle, reads the register file
`default_nettype none

`include "cpu_config.svh"

module decodeStage
    import isaPkg::*, datapathPkg::*;
(
    input  wire logic    clk,
    input  wire word_t   pc,
    input  wire word_t   instr,
    input  wire logic    wbEn,
    input  wire regIdx_t wbReg,
    input  wire word_t   wbData,
    output decodeOut_t   decodeOut
);

    localparam regIdx_t LINK_REG = regIdx_t'(`REG_COUNT - 1);

    instrFields_t fields;
    ctrl_t        ctrl;
    word_t        regFile [`REG_COUNT];
    regIdx_t      rs;
    regIdx_t      rt;
    regIdx_t      rd;
    imm_t         imm;

    assign fields = instr;
    assign rs     = fields.body.rFmt.rs;
    assign rt     = fields.body.rFmt.rt;
    assign rd     = fields.body.rFmt.rd;
    assign imm    = fields.body.iFmt.imm;

    // unknown encodings fall through with everything off
    always_comb begin
        ctrl = '0;
        case (fields.op)
            RTYPE: begin
                case (fields.body.rFmt.funct)
                    ADD: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_ADD;
                    end
                    SUB: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_SUB;
                    end
                    AND: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_AND;
                    end
                    OR: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_OR;
                    end
                    SLT: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ALU_SLT;
                    end
                    JR: begin
                        ctrl.jump    = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    default: ;
                endcase
            end
            ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_ADD;
            end
            LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluOp     = ALU_ADD; // base + offset
            end
            SW: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.aluOp     = ALU_ADD;
            end
            BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB; // equality via zero test
            end
            J: ctrl.jump = 1'b1;
            JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

    // writes to r0 are dropped here
    always_ff @(posedge clk) begin
        if (wbEn && wbReg != '0) begin
            regFile[wbReg] <= wbData;
        end
    end

    always_comb begin
        decodeOut.ctrl      = ctrl;
        decodeOut.readData1 = (rs == '0) ? '0 : regFile[rs];
        decodeOut.readData2 = (rt == '0) ? '0 : regFile[rt];
        decodeOut.seImm     = {{(`DATA_W - 16){imm[15]}}, imm};
        decodeOut.target    = fields.body.target;
        decodeOut.pcPlus4   = pc + word_t'(4);
        if (ctrl.link) begin
            decodeOut.writeReg = LINK_REG;
        end else begin
            decodeOut.writeReg = ctrl.regDst ? rd : rt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
// Execute stage
// ALU plus branch and jump resolution
`default_nettype none

module executeStage
    import isaPkg::*, datapathPkg::*;
(
    input  wire decodeOut_t decodeOut,
    output execOut_t        execOut
);

    word_t aluA;
    word_t aluB;
    word_t aluResult;
    logic  zero;

    assign aluA = decodeOut.readData1;
    assign aluB = decodeOut.ctrl.aluSrcImm ? decodeOut.seImm : decodeOut.readData2;

    always_comb begin
        case (decodeOut.ctrl.aluOp)
            ALU_ADD: aluResult = aluA + aluB;
            ALU_SUB: aluResult = aluA - aluB;
            ALU_AND: aluResult = aluA & aluB;
            ALU_OR:  aluResult = aluA | aluB;
            ALU_SLT: aluResult = word_t'($signed(aluA) < $signed(aluB)); // signed compare
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    always_comb begin
        execOut.ctrl         = decodeOut.ctrl;
        execOut.aluResult    = aluResult;
        execOut.storeData    = decodeOut.readData2;
        execOut.writeReg     = decodeOut.writeReg;
        execOut.pcPlus4      = decodeOut.pcPlus4;
        execOut.takeBranch   = decodeOut.ctrl.branch & zero;
        execOut.branchTarget = decodeOut.pcPlus4 + {decodeOut.seImm[29:0], 2'b00};
        execOut.takeJump     = decodeOut.ctrl.jump;
        // jr goes through rs, j and jal stay in the current 256MB region
        if (decodeOut.ctrl.jumpReg) begin
            execOut.jumpTarget = decodeOut.readData1;
        end else begin
            execOut.jumpTarget = {decodeOut.pcPlus4[31:28], decodeOut.target, 2'b00};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetchStage.sv ====
// Fetch stage
// PC register, instruction memory with loader port, next-PC selection
`default_nettype none

`include "cpu_config.svh"

module fetchStage
    import isaPkg::*, datapathPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     run,
    input  wire logic     imemWe,
    input  wire word_t    imemAddr, // word index, not byte address
    input  wire word_t    imemData,
    input  wire execOut_t execOut,
    output word_t         pc,
    output word_t         instr
);

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);

    word_t imem [`IMEM_WORDS];
    word_t nextPc;

    // loader write port
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr[IMEM_AW-1:0]] <= imemData;
        end
    end

    assign instr = imem[pc[IMEM_AW+1:2]]; // drop byte offset

    // jumps win over branches, both resolved in execute
    always_comb begin
        if (execOut.takeJump) begin
            nextPc = execOut.jumpTarget;
        end else if (execOut.takeBranch) begin
            nextPc = execOut.branchTarget;
        end else begin
            nextPc = execOut.pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc; // holds while stopped
        end
    end

endmodule

`default_nettype wire

// ==== verilog/isaPkg.sv ====
// ISA package
// instruction encodings and field layout for the MIPS-like subset
`default_nettype none

`include "cpu_config.svh"

package isaPkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [4:0]         regIdx_t;
    typedef logic [15:0]        imm_t;
    typedef logic [25:0]        jumpTarget_t;

    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        ADDI  = 6'h08,
        LW    = 6'h23,
        SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        JR  = 6'h08,
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_e;

    typedef struct packed {
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt; // unused by this subset
        funct_e     funct;
    } rFields_t;

    typedef struct packed {
        regIdx_t rs;
        regIdx_t rt;
        imm_t    imm;
    } iFields_t;

    // the three formats overlay the low 26 bits
    typedef union packed {
        rFields_t    rFmt;
        iFields_t    iFmt;
        jumpTarget_t target;
    } instrBody_t;

    typedef struct packed {
        opcode_e    op;
        instrBody_t body;
    } instrFields_t;

endpackage

`default_nettype wire

// ==== verilog/memoryStage.sv ====
// Memory and writeback stage
// data memory, writeback select and the retire record
`default_nettype none

`include "cpu_config.svh"

module memoryStage
    import isaPkg::*, datapathPkg::*;
(
    input  wire logic     clk,
    input  wire logic     run,
    input  wire word_t    pc,
    input  wire execOut_t execOut,
    output logic          wbEn,
    output regIdx_t       wbReg,
    output word_t         wbData,
    output logic          retireValid,
    output retire_t       retire
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    word_t               dmem [`DMEM_WORDS];
    logic [DMEM_AW-1:0]  dmemIdx;
    word_t               loadData;
    logic                memWe;

    assign dmemIdx  = execOut.aluResult[DMEM_AW+1:2]; // word index
    assign loadData = dmem[dmemIdx];                  // lw reads in the same cycle
    assign memWe    = run & execOut.ctrl.memWrite;

    always_ff @(posedge clk) begin
        if (memWe) begin
            dmem[dmemIdx] <= execOut.storeData;
        end
    end

    assign wbEn  = run & execOut.ctrl.regWrite;
    assign wbReg = execOut.writeReg;

    always_comb begin
        if (execOut.ctrl.link) begin
            wbData = execOut.pcPlus4;
        end else if (execOut.ctrl.memToReg) begin
            wbData = loadData;
        end else begin
            wbData = execOut.aluResult;
        end
    end

    // unused trace fields read as zero
    assign retireValid    = run;
    assign retire.pc      = pc;
    assign retire.wbEn    = wbEn;
    assign retire.wbReg   = wbEn ? wbReg : '0;
    assign retire.wbData  = wbEn ? wbData : '0;
    assign retire.memWe   = memWe;
    assign retire.memAddr = memWe ? execOut.aluResult : '0;
    assign retire.memData = memWe ? execOut.storeData : '0;

endmodule

`default_nettype wire

// ==== verilog/singleCycleCpu.sv ====
// Single-cycle CPU top
// fetch, decode, execute and memory stages chained within one cycle
`default_nettype none

module singleCycleCpu
    import isaPkg::*, datapathPkg::*;
(
    input  wire logic  clk,
    input  wire logic  rstN,
    input  wire logic  run,
    input  wire logic  imemWe,
    input  wire word_t imemAddr,
    input  wire word_t imemData,
    output logic       retireValid,
    output retire_t    retire
);

    word_t      pc;
    word_t      instr;
    decodeOut_t decodeOut;
    execOut_t   execOut;
    logic       wbEn;
    regIdx_t    wbReg;
    word_t      wbData;

    fetchStage fetch (
        .clk      (clk),
        .rstN     (rstN),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .execOut  (execOut),  // next-PC feedback
        .pc       (pc),
        .instr    (instr)
    );

    decodeStage decode (
        .clk       (clk),
        .pc        (pc),
        .instr     (instr),
        .wbEn      (wbEn),
        .wbReg     (wbReg),
        .wbData    (wbData),
        .decodeOut (decodeOut)
    );

    executeStage execute (
        .decodeOut (decodeOut),
        .execOut   (execOut)
    );

    memoryStage memory (
        .clk         (clk),
        .run         (run),
        .pc          (pc),
        .execOut     (execOut),
        .wbEn        (wbEn),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .retireValid (retireValid),
        .retire      (retire)
    );

endmodule

`default_nettype wire
